// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f rv_core.f

./obj_dir/Vrv_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

// File: rv_core.f
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_mem_wb.sv
rv_core.sv
rv_core_asserts.sv
rv_core_tb.sv

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic                          clk,
  input  logic                          i_arst_n,
  input  logic [rv_isa_pkg::XLEN-1:0]   i_imem_data,
  output logic [rv_isa_pkg::XLEN-1:0]   o_imem_addr,
  output logic                          o_wb_valid,  // Register write strobe
  output logic [rv_isa_pkg::REG_AW-1:0] o_wb_rd,
  output logic [rv_isa_pkg::XLEN-1:0]   o_wb_data
);

  logic        redirect;
  logic [31:0] redirect_pc;
  logic [31:0] id_pc;
  logic [31:0] id_instr;
  logic [31:0] ex_pc;
  logic [31:0] ex_rs1_data;
  logic [31:0] ex_rs2_data;
  logic [31:0] ex_imm;
  logic [4:0]  ex_rs1;
  logic [4:0]  ex_rs2;
  logic [4:0]  ex_rd;
  logic [3:0]  ex_alu_op;
  logic        ex_srca;
  logic        ex_srcb;
  logic [1:0]  ex_res_sel;
  logic        ex_wr_en;
  logic        ex_is_br;
  logic        ex_is_jal;
  logic        ex_is_jalr;
  logic [2:0]  ex_br_f3;
  logic [31:0] mem_pc;
  logic [31:0] mem_alu;
  logic [31:0] mem_imm;
  logic [4:0]  mem_rd;
  logic [1:0]  mem_res_sel;
  logic        mem_wr_en;
  logic [31:0] mem_result;

  rv_fetch u_fetch (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_imem_data   (i_imem_data),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_imem_addr   (o_imem_addr),
    .o_id_pc       (id_pc),
    .o_id_instr    (id_instr)
  );

  rv_decode u_decode (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_id_pc       (id_pc),
    .i_id_instr    (id_instr),
    .i_flush       (redirect),
    .i_wb_wr_en    (o_wb_valid),
    .i_wb_rd       (o_wb_rd),
    .i_wb_data     (o_wb_data),
    .o_ex_pc       (ex_pc),
    .o_ex_rs1_data (ex_rs1_data),
    .o_ex_rs2_data (ex_rs2_data),
    .o_ex_imm      (ex_imm),
    .o_ex_rs1      (ex_rs1),
    .o_ex_rs2      (ex_rs2),
    .o_ex_rd       (ex_rd),
    .o_ex_alu_op   (ex_alu_op),
    .o_ex_srca     (ex_srca),
    .o_ex_srcb     (ex_srcb),
    .o_ex_res_sel  (ex_res_sel),
    .o_ex_wr_en    (ex_wr_en),
    .o_ex_is_br    (ex_is_br),
    .o_ex_is_jal   (ex_is_jal),
    .o_ex_is_jalr  (ex_is_jalr),
    .o_ex_br_f3    (ex_br_f3)
  );

  rv_execute u_execute (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_ex_pc       (ex_pc),
    .i_ex_rs1_data (ex_rs1_data),
    .i_ex_rs2_data (ex_rs2_data),
    .i_ex_imm      (ex_imm),
    .i_ex_rs1      (ex_rs1),
    .i_ex_rs2      (ex_rs2),
    .i_ex_rd       (ex_rd),
    .i_ex_alu_op   (ex_alu_op),
    .i_ex_srca     (ex_srca),
    .i_ex_srcb     (ex_srcb),
    .i_ex_res_sel  (ex_res_sel),
    .i_ex_wr_en    (ex_wr_en),
    .i_ex_is_br    (ex_is_br),
    .i_ex_is_jal   (ex_is_jal),
    .i_ex_is_jalr  (ex_is_jalr),
    .i_ex_br_f3    (ex_br_f3),
    .i_mem_wr_en   (mem_wr_en),
    .i_mem_rd      (mem_rd),
    .i_mem_result  (mem_result),
    .i_wb_wr_en    (o_wb_valid),
    .i_wb_rd       (o_wb_rd),
    .i_wb_result   (o_wb_data),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .o_mem_pc      (mem_pc),
    .o_mem_alu     (mem_alu),
    .o_mem_imm     (mem_imm),
    .o_mem_rd      (mem_rd),
    .o_mem_res_sel (mem_res_sel),
    .o_mem_wr_en   (mem_wr_en)
  );

  // WB enable only ever set for rd != x0, so it doubles as the strobe
  rv_mem_wb u_mem_wb (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_mem_pc      (mem_pc),
    .i_mem_alu     (mem_alu),
    .i_mem_imm     (mem_imm),
    .i_mem_rd      (mem_rd),
    .i_mem_res_sel (mem_res_sel),
    .i_mem_wr_en   (mem_wr_en),
    .o_mem_result  (mem_result),
    .o_wb_wr_en    (o_wb_valid),
    .o_wb_rd       (o_wb_rd),
    .o_wb_result   (o_wb_data)
  );

endmodule

// File: rv_core_asserts.sv
`timescale 1ns/10ps

module rv_core_asserts (
  input logic                          clk,
  input logic                          i_arst_n,
  input logic [rv_isa_pkg::XLEN-1:0]   i_imem_addr,
  input logic                          i_wb_valid,
  input logic [rv_isa_pkg::REG_AW-1:0] i_wb_rd,
  input logic [rv_isa_pkg::XLEN-1:0]   i_wb_data
);

  int fail_count = 0;  // Read by the testbench at the end

  // x0 writes stay inside the core
  a_no_x0_write: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_wb_valid |-> i_wb_rd != '0)
    else begin
      fail_count++;
      $error("write-back strobe with rd of x0");
    end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_imem_addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("fetch address not word aligned");
    end

  a_data_known: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_wb_valid |-> !$isunknown(i_wb_data))
    else begin
      fail_count++;
      $error("unknown write-back data while valid");
    end

  // Pipeline is all bubbles right after reset
  a_quiet_after_reset: assert property (@(posedge clk) $rose(i_arst_n) |-> !i_wb_valid)
    else begin
      fail_count++;
      $error("write-back strobe in the first cycle after reset");
    end

endmodule

bind rv_core rv_core_asserts u_asserts (
  .clk         (clk),
  .i_arst_n    (i_arst_n),
  .i_imem_addr (o_imem_addr),
  .i_wb_valid  (o_wb_valid),
  .i_wb_rd     (o_wb_rd),
  .i_wb_data   (o_wb_data)
);

// File: rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

  localparam int          PROG_WORDS  = 200;
  localparam int          TIMEOUT_CYC = 5000;
  localparam logic [31:0] HALT_PC     = rv_pipe_pkg::RESET_PC + 32'(4 * (PROG_WORDS - 1));

  logic        clk;
  logic        i_arst_n;
  logic [31:0] i_imem_data;
  logic [31:0] o_imem_addr;
  logic        o_wb_valid;
  logic [4:0]  o_wb_rd;
  logic [31:0] o_wb_data;

  logic [31:0] prog [PROG_WORDS];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_fetch [$];
  int          err_count;
  int          retired;
  int          expected;

  rv_core DUT (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_imem_data (i_imem_data),
    .o_imem_addr (o_imem_addr),
    .o_wb_valid  (o_wb_valid),
    .o_wb_rd     (o_wb_rd),
    .o_wb_data   (o_wb_data)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] imem_read(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - rv_pipe_pkg::RESET_PC) >> 2;
    if (idx < 32'(PROG_WORDS)) begin
      return prog[idx[7:0]];
    end
    return rv_pipe_pkg::NOP_WORD;  // Outside the program
  endfunction

  // Instruction memory answers the new PC shortly after each edge
  always @(posedge clk) begin
    #1 i_imem_data = imem_read(o_imem_addr);
  end

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      rv_isa_pkg::F3_ADD:  return alt ? a - b : a + b;
      rv_isa_pkg::F3_SLL:  return a << b[4:0];
      rv_isa_pkg::F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_isa_pkg::F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      rv_isa_pkg::F3_XOR:  return a ^ b;
      rv_isa_pkg::F3_SR: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      rv_isa_pkg::F3_OR:   return a | b;
      default:             return a & b;
    endcase
  endfunction

  function automatic logic br_model(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
      rv_isa_pkg::F3_BEQ:  return a == b;
      rv_isa_pkg::F3_BNE:  return a != b;
      rv_isa_pkg::F3_BLT:  return $signed(a) < $signed(b);
      rv_isa_pkg::F3_BGE:  return $signed(a) >= $signed(b);
      rv_isa_pkg::F3_BLTU: return a < b;
      default:             return a >= b;
    endcase
  endfunction

  // Small register set so that close dependencies are frequent
  task automatic build_program();
    int          kind;
    int          span;
    int          t;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] imm;
    logic [31:0] off;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      kind = int'($urandom_range(0, 12));
      rd   = 5'($urandom_range(0, 7));
      rs1  = 5'($urandom_range(0, 7));
      rs2  = 5'($urandom_range(0, 7));
      f3   = 3'($urandom_range(0, 7));
      alt  = 1'($urandom_range(0, 1));
      imm  = $urandom;
      span = (PROG_WORDS - 2 - i < 4) ? PROG_WORDS - 2 - i : 4;
      t    = i + 1 + int'($urandom_range(0, span));  // Forward target that never passes the halt
      off  = 32'((t - i) * 4);
      if (kind < 4) begin
        alt = alt && (f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR);
        prog[i] = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
      end else if (kind < 8) begin
        if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SR) begin
          imm[11:5] = (alt && f3 == rv_isa_pkg::F3_SR) ? 7'h20 : 7'h00;  // Legal shamt form
        end
        prog[i] = {imm[11:0], rs1, f3, rd, rv_isa_pkg::OP_IMM};
      end else if (kind == 8) begin
        prog[i] = {imm[19:0], rd, alt ? rv_isa_pkg::OP_LUI : rv_isa_pkg::OP_AUIPC};
      end else if (kind < 11) begin
        f3 = 3'($urandom_range(0, 5));
        if (f3 >= 3'd2) begin
          f3 = f3 + 3'd2;  // Skip the two unused branch codes
        end
        prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OP_BR};
      end else if (kind == 11) begin
        prog[i] = {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OP_JAL};
      end else begin
        imm = rv_pipe_pkg::RESET_PC + 32'(t * 4);  // Absolute target from base x0
        prog[i] = {imm[11:0], 5'd0, 3'b000, rd, rv_isa_pkg::OP_JALR};
      end
    end
    prog[PROG_WORDS - 1] = {20'h00000, 5'd0, rv_isa_pkg::OP_JAL};  // jal x0, 0
  endtask

  task automatic run_model();
    logic [31:0]           regs [32];
    logic [31:0]           pc;
    logic [31:0]           nxt;
    logic [31:0]           idx;
    logic [31:0]           a;
    logic [31:0]           b;
    logic [31:0]           imm;
    logic [31:0]           res;
    logic                  wr;
    logic                  taken;
    rv_isa_pkg::rv_instr_u w;
    int                    steps;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    pc    = rv_pipe_pkg::RESET_PC;
    steps = 0;
    while (pc != HALT_PC && steps < 10000) begin
      idx   = (pc - rv_pipe_pkg::RESET_PC) >> 2;
      w     = prog[idx[7:0]];
      a     = regs[w.r.rs1];
      b     = regs[w.r.rs2];
      imm   = {{20{w.i.imm12[11]}}, w.i.imm12};
      nxt   = pc + 32'd4;
      res   = '0;
      wr    = 1'b1;
      taken = 1'b0;
      case (w.r.opcode)
        rv_isa_pkg::OP_REG:   res = alu_model(w.r.funct3, w.r.funct7[5], a, b);
        rv_isa_pkg::OP_IMM:   res = alu_model(w.r.funct3,
                                              w.r.funct3 == rv_isa_pkg::F3_SR && imm[10], a, imm);
        rv_isa_pkg::OP_LUI:   res = {w.u.imm20, 12'h000};
        rv_isa_pkg::OP_AUIPC: res = pc + {w.u.imm20, 12'h000};
        rv_isa_pkg::OP_JAL: begin
          res   = pc + 32'd4;
          taken = 1'b1;
          nxt   = pc + {{11{w.u.imm20[19]}}, w.u.imm20[19], w.u.imm20[7:0], w.u.imm20[8],
                        w.u.imm20[18:9], 1'b0};
        end
        rv_isa_pkg::OP_JALR: begin
          res   = pc + 32'd4;
          taken = 1'b1;
          nxt   = (a + imm) & ~32'd1;
        end
        rv_isa_pkg::OP_BR: begin
          wr    = 1'b0;
          taken = br_model(w.r.funct3, a, b);
          if (taken) begin
            nxt = pc + {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
          end
        end
        default: wr = 1'b0;
      endcase
      if (wr && w.r.rd != 5'd0) begin
        regs[w.r.rd] = res;
        exp_rd.push_back(w.r.rd);
        exp_data.push_back(res);
      end
      exp_fetch.push_back(pc);
      if (taken) begin
        exp_fetch.push_back(pc + 32'd4);  // Two wrong-path fetches before the redirect
        exp_fetch.push_back(pc + 32'd8);
      end
      pc    = nxt;
      steps = steps + 1;
    end
    if (pc != HALT_PC) begin
      $display("Reference model never reached the halt instruction");
      err_count++;
    end else begin
      exp_fetch.push_back(pc);
    end
  endtask

  task automatic check_rd(input logic [rv_isa_pkg::REG_AW-1:0] got,
                          input logic [rv_isa_pkg::REG_AW-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: write-back rd x%0d, expected x%0d", $time, got, exp);
      err_count++;
    end
  endtask

  task automatic check_data(input logic [rv_isa_pkg::XLEN-1:0] got,
                            input logic [rv_isa_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: write-back data %h, expected %h", $time, got, exp);
      err_count++;
    end
  endtask

  task automatic check_addr(input logic [rv_isa_pkg::XLEN-1:0] got,
                            input logic [rv_isa_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: fetch address %h, expected %h", $time, got, exp);
      err_count++;
    end
  endtask

  // Sampled mid-cycle away from the edge
  always @(negedge clk) begin
    if (i_arst_n && exp_fetch.size() != 0) begin
      check_addr(o_imem_addr, exp_fetch.pop_front());
    end
    if (i_arst_n && o_wb_valid) begin
      retired++;
      if (exp_rd.size() == 0) begin
        $display("Write-back to x%0d at %0t that the model never made", o_wb_rd, $time);
        err_count++;
      end else begin
        check_rd(o_wb_rd, exp_rd.pop_front());
        check_data(o_wb_data, exp_data.pop_front());
      end
    end
  end

  task automatic wait_queue_drained();
    int cyc;
    cyc = 0;
    while (exp_rd.size() != 0 && cyc < TIMEOUT_CYC) begin
      @(negedge clk);
      cyc++;
    end
    if (exp_rd.size() != 0) begin
      $display("Timeout: %0d predicted writes never reached write-back", exp_rd.size());
      err_count++;
    end
  endtask

  task automatic wait_halt_fetched();
    int cyc;
    cyc = 0;
    while (exp_fetch.size() != 0 && cyc < TIMEOUT_CYC) begin
      @(negedge clk);
      cyc++;
    end
    if (exp_fetch.size() != 0) begin
      $display("Timeout: the core never fetched the halt instruction");
      err_count++;
    end
  endtask

  initial begin
    void'($urandom(32'ha7b0823d));
    clk         = 1'b0;
    i_arst_n    = 1'b0;
    i_imem_data = rv_pipe_pkg::NOP_WORD;
    err_count   = 0;
    retired     = 0;
    build_program();
    run_model();
    expected = exp_rd.size();
    repeat (4) @(posedge clk);
    #1 i_arst_n = 1'b1;
    wait_queue_drained();
    wait_halt_fetched();
    repeat (6) @(posedge clk);  // Halt reaches WB four cycles after fetch and writes nothing
    if (retired != expected) begin
      $display("Core retired %0d writes but the model made %0d", retired, expected);
      err_count++;
    end
    $display("Errors: %0d, assertion failures: %0d, retired writes: %0d of %0d",
             err_count, DUT.u_asserts.fail_count, retired, expected);
    if (err_count == 0 && DUT.u_asserts.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
  input  logic        clk,
  input  logic        i_arst_n,
  input  logic [31:0] i_id_pc,
  input  logic [31:0] i_id_instr,
  input  logic        i_flush,
  input  logic        i_wb_wr_en,
  input  logic [4:0]  i_wb_rd,
  input  logic [31:0] i_wb_data,
  output logic [31:0] o_ex_pc,
  output logic [31:0] o_ex_rs1_data,
  output logic [31:0] o_ex_rs2_data,
  output logic [31:0] o_ex_imm,
  output logic [4:0]  o_ex_rs1,
  output logic [4:0]  o_ex_rs2,
  output logic [4:0]  o_ex_rd,
  output logic [3:0]  o_ex_alu_op,
  output logic        o_ex_srca,
  output logic        o_ex_srcb,
  output logic [1:0]  o_ex_res_sel,
  output logic        o_ex_wr_en,
  output logic        o_ex_is_br,
  output logic        o_ex_is_jal,
  output logic        o_ex_is_jalr,
  output logic [2:0]  o_ex_br_f3
);

  rv_isa_pkg::rv_instr_u instr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic        alt_op;
  logic [3:0]  dec_alu_op;
  logic        dec_srca;
  logic        dec_srcb;
  logic [1:0]  dec_res_sel;
  logic [31:0] dec_imm;
  logic        dec_writes;
  logic        dec_is_br;
  logic        dec_is_jal;
  logic        dec_is_jalr;

  assign instr = i_id_instr;

  assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
  assign imm_u = {instr.u.imm20, 12'b0};
  assign imm_j = {{11{instr.u.imm20[19]}}, instr.u.imm20[19], instr.u.imm20[7:0],
                  instr.u.imm20[8], instr.u.imm20[18:9], 1'b0};

  // Bit 30 means SUB/SRA for register ops, but only SRAI among immediates
  assign alt_op = instr.r.funct7[5] &&
                  (instr.r.opcode == rv_isa_pkg::OP_REG || instr.r.funct3 == rv_isa_pkg::F3_SR);

  function automatic logic [3:0] alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      rv_isa_pkg::F3_ADD:  return alt ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:  return rv_pipe_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:  return rv_pipe_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU: return rv_pipe_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:  return rv_pipe_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:   return alt ? rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:   return rv_pipe_pkg::ALU_OR;
      default:             return rv_pipe_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec_alu_op  = rv_pipe_pkg::ALU_ADD;
    dec_srca    = rv_pipe_pkg::SRCA_RS1;
    dec_srcb    = rv_pipe_pkg::SRCB_IMM;
    dec_res_sel = rv_pipe_pkg::RES_ALU;
    dec_imm     = imm_i;
    dec_writes  = 1'b0;
    dec_is_br   = 1'b0;
    dec_is_jal  = 1'b0;
    dec_is_jalr = 1'b0;
    case (instr.r.opcode)
      rv_isa_pkg::OP_LUI: begin
        dec_imm     = imm_u;
        dec_res_sel = rv_pipe_pkg::RES_IMM;
        dec_writes  = 1'b1;
      end
      rv_isa_pkg::OP_AUIPC: begin
        dec_imm    = imm_u;
        dec_srca   = rv_pipe_pkg::SRCA_PC;
        dec_writes = 1'b1;
      end
      rv_isa_pkg::OP_JAL: begin
        dec_imm     = imm_j;
        dec_srca    = rv_pipe_pkg::SRCA_PC;  // Target is PC + offset
        dec_res_sel = rv_pipe_pkg::RES_PC4;
        dec_writes  = 1'b1;
        dec_is_jal  = 1'b1;
      end
      rv_isa_pkg::OP_JALR: begin
        dec_res_sel = rv_pipe_pkg::RES_PC4;
        dec_writes  = 1'b1;
        dec_is_jalr = 1'b1;
      end
      rv_isa_pkg::OP_BR: begin
        dec_imm   = imm_b;
        dec_srca  = rv_pipe_pkg::SRCA_PC;
        dec_is_br = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        dec_alu_op = alu_sel(instr.r.funct3, alt_op);
        dec_writes = 1'b1;
      end
      rv_isa_pkg::OP_REG: begin
        dec_alu_op = alu_sel(instr.r.funct3, alt_op);
        dec_srcb   = rv_pipe_pkg::SRCB_RS2;
        dec_writes = 1'b1;
      end
      default: ;  // Unknown opcode runs as a bubble
    endcase
  end

  rv_regfile u_regfile (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_rs1      (instr.r.rs1),
    .i_rs2      (instr.r.rs2),
    .i_wr_en    (i_wb_wr_en),
    .i_wr_rd    (i_wb_rd),
    .i_wr_data  (i_wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // ID/EX control is cleared on redirect
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ex_wr_en   <= 1'b0;
      o_ex_is_br   <= 1'b0;
      o_ex_is_jal  <= 1'b0;
      o_ex_is_jalr <= 1'b0;
    end else if (i_flush) begin
      o_ex_wr_en   <= 1'b0;
      o_ex_is_br   <= 1'b0;
      o_ex_is_jal  <= 1'b0;
      o_ex_is_jalr <= 1'b0;
    end else begin
      o_ex_wr_en   <= dec_writes && instr.r.rd != 5'd0;  // x0 never written
      o_ex_is_br   <= dec_is_br;
      o_ex_is_jal  <= dec_is_jal;
      o_ex_is_jalr <= dec_is_jalr;
    end
  end

  always_ff @(posedge clk) begin
    o_ex_pc       <= i_id_pc;
    o_ex_rs1_data <= rs1_data;
    o_ex_rs2_data <= rs2_data;
    o_ex_imm      <= dec_imm;
    o_ex_rs1      <= instr.r.rs1;
    o_ex_rs2      <= instr.r.rs2;
    o_ex_rd       <= instr.r.rd;
    o_ex_alu_op   <= dec_alu_op;
    o_ex_srca     <= dec_srca;
    o_ex_srcb     <= dec_srcb;
    o_ex_res_sel  <= dec_res_sel;
    o_ex_br_f3    <= instr.r.funct3;
  end

endmodule

// File: rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
  input  logic        clk,
  input  logic        i_arst_n,
  input  logic [31:0] i_ex_pc,
  input  logic [31:0] i_ex_rs1_data,
  input  logic [31:0] i_ex_rs2_data,
  input  logic [31:0] i_ex_imm,
  input  logic [4:0]  i_ex_rs1,
  input  logic [4:0]  i_ex_rs2,
  input  logic [4:0]  i_ex_rd,
  input  logic [3:0]  i_ex_alu_op,
  input  logic        i_ex_srca,
  input  logic        i_ex_srcb,
  input  logic [1:0]  i_ex_res_sel,
  input  logic        i_ex_wr_en,
  input  logic        i_ex_is_br,
  input  logic        i_ex_is_jal,
  input  logic        i_ex_is_jalr,
  input  logic [2:0]  i_ex_br_f3,
  input  logic        i_mem_wr_en,
  input  logic [4:0]  i_mem_rd,
  input  logic [31:0] i_mem_result,
  input  logic        i_wb_wr_en,
  input  logic [4:0]  i_wb_rd,
  input  logic [31:0] i_wb_result,
  output logic        o_redirect,
  output logic [31:0] o_redirect_pc,
  output logic [31:0] o_mem_pc,
  output logic [31:0] o_mem_alu,
  output logic [31:0] o_mem_imm,
  output logic [4:0]  o_mem_rd,
  output logic [1:0]  o_mem_res_sel,
  output logic        o_mem_wr_en
);

  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_out;
  logic        br_taken;

  // Youngest producer wins so MEM beats WB and WB beats the register file
  function automatic logic [31:0] fwd(input logic [4:0] rs, input logic [31:0] rf_val);
    if (i_mem_wr_en && i_mem_rd == rs && rs != 5'd0) begin
      return i_mem_result;
    end else if (i_wb_wr_en && i_wb_rd == rs && rs != 5'd0) begin
      return i_wb_result;
    end
    return rf_val;
  endfunction

  always_comb begin
    rs1_val = fwd(i_ex_rs1, i_ex_rs1_data);
    rs2_val = fwd(i_ex_rs2, i_ex_rs2_data);
  end

  assign op_a    = (i_ex_srca == rv_pipe_pkg::SRCA_PC)  ? i_ex_pc  : rs1_val;
  assign op_b    = (i_ex_srcb == rv_pipe_pkg::SRCB_IMM) ? i_ex_imm : rs2_val;

  always_comb begin
    case (i_ex_alu_op)
      rv_pipe_pkg::ALU_SUB:  alu_out = op_a - op_b;
      rv_pipe_pkg::ALU_SLL:  alu_out = op_a << op_b[4:0];
      rv_pipe_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pipe_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
      rv_pipe_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
      rv_pipe_pkg::ALU_SRL:  alu_out = op_a >> op_b[4:0];
      rv_pipe_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
      rv_pipe_pkg::ALU_OR:   alu_out = op_a | op_b;
      rv_pipe_pkg::ALU_AND:  alu_out = op_a & op_b;
      default:               alu_out = op_a + op_b;  // Also address sums
    endcase
  end

  always_comb begin
    case (i_ex_br_f3)
      rv_isa_pkg::F3_BEQ:  br_taken = rs1_val == rs2_val;
      rv_isa_pkg::F3_BNE:  br_taken = rs1_val != rs2_val;
      rv_isa_pkg::F3_BLT:  br_taken = $signed(rs1_val) < $signed(rs2_val);
      rv_isa_pkg::F3_BGE:  br_taken = $signed(rs1_val) >= $signed(rs2_val);
      rv_isa_pkg::F3_BLTU: br_taken = rs1_val < rs2_val;
      rv_isa_pkg::F3_BGEU: br_taken = rs1_val >= rs2_val;
      default:             br_taken = 1'b0;
    endcase
  end

  assign o_redirect    = i_ex_is_jal || i_ex_is_jalr || (i_ex_is_br && br_taken);
  assign o_redirect_pc = {alu_out[31:1], alu_out[0] & ~i_ex_is_jalr};  // JALR drops bit 0

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_mem_wr_en <= 1'b0;
    end else begin
      o_mem_wr_en <= i_ex_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    o_mem_pc      <= i_ex_pc;
    o_mem_alu     <= alu_out;
    o_mem_imm     <= i_ex_imm;
    o_mem_rd      <= i_ex_rd;
    o_mem_res_sel <= i_ex_res_sel;
  end

endmodule

// File: rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch (
  input  logic        clk,
  input  logic        i_arst_n,
  input  logic [31:0] i_imem_data,
  input  logic        i_redirect,
  input  logic [31:0] i_redirect_pc,
  output logic [31:0] o_imem_addr,
  output logic [31:0] o_id_pc,
  output logic [31:0] o_id_instr
);

  logic [31:0] pc;
  logic [31:0] pc_next;

  // Taken branch or jump in EX wins over sequential fetch
  assign pc_next     = i_redirect ? i_redirect_pc : pc + 32'd4;
  assign o_imem_addr = pc;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc         <= rv_pipe_pkg::RESET_PC;
      o_id_instr <= rv_pipe_pkg::NOP_WORD;
    end else begin
      pc <= pc_next;
      if (i_redirect) begin
        o_id_instr <= rv_pipe_pkg::NOP_WORD;  // Kill the wrong-path fetch
      end else begin
        o_id_instr <= i_imem_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    o_id_pc <= pc;
  end

endmodule

// File: rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // Major opcodes
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_JAL   = 7'b1101111;
  localparam logic [6:0] OP_JALR  = 7'b1100111;
  localparam logic [6:0] OP_BR    = 7'b1100011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG   = 7'b0110011;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // ALU operations where funct7 bit 5 picks SUB and SRA
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // One instruction word seen through each field layout
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } rv_instr_u;

endpackage

// File: rv_mem_wb.sv
`timescale 1ns/10ps

module rv_mem_wb (
  input  logic        clk,
  input  logic        i_arst_n,
  input  logic [31:0] i_mem_pc,
  input  logic [31:0] i_mem_alu,
  input  logic [31:0] i_mem_imm,
  input  logic [4:0]  i_mem_rd,
  input  logic [1:0]  i_mem_res_sel,
  input  logic        i_mem_wr_en,
  output logic [31:0] o_mem_result,
  output logic        o_wb_wr_en,
  output logic [4:0]  o_wb_rd,
  output logic [31:0] o_wb_result
);

  // Result is final here, so MEM can forward it
  always_comb begin
    case (i_mem_res_sel)
      rv_pipe_pkg::RES_IMM: o_mem_result = i_mem_imm;
      rv_pipe_pkg::RES_PC4: o_mem_result = i_mem_pc + 32'd4;
      default:              o_mem_result = i_mem_alu;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_wr_en <= 1'b0;
    end else begin
      o_wb_wr_en <= i_mem_wr_en;
    end
  end

  always_ff @(posedge clk) begin
    o_wb_rd     <= i_mem_rd;
    o_wb_result <= o_mem_result;
  end

endmodule

// File: rv_pipe_pkg.sv
package rv_pipe_pkg;

  // ALU operation codes
  localparam logic [3:0] ALU_ADD  = 4'd0;
  localparam logic [3:0] ALU_SUB  = 4'd1;
  localparam logic [3:0] ALU_SLL  = 4'd2;
  localparam logic [3:0] ALU_SLT  = 4'd3;
  localparam logic [3:0] ALU_SLTU = 4'd4;
  localparam logic [3:0] ALU_XOR  = 4'd5;
  localparam logic [3:0] ALU_SRL  = 4'd6;
  localparam logic [3:0] ALU_SRA  = 4'd7;
  localparam logic [3:0] ALU_OR   = 4'd8;
  localparam logic [3:0] ALU_AND  = 4'd9;

  // Operand selects
  localparam logic SRCA_RS1 = 1'b0;
  localparam logic SRCA_PC  = 1'b1;
  localparam logic SRCB_RS2 = 1'b0;
  localparam logic SRCB_IMM = 1'b1;

  // Register write value select
  localparam logic [1:0] RES_ALU = 2'd0;
  localparam logic [1:0] RES_IMM = 2'd1;  // LUI
  localparam logic [1:0] RES_PC4 = 2'd2;  // Link value of jumps

  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;  // addi x0, x0, 0

endpackage

// File: rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          i_arst_n,
  input  logic [rv_isa_pkg::REG_AW-1:0] i_rs1,
  input  logic [rv_isa_pkg::REG_AW-1:0] i_rs2,
  input  logic                          i_wr_en,
  input  logic [rv_isa_pkg::REG_AW-1:0] i_wr_rd,
  input  logic [rv_isa_pkg::XLEN-1:0]   i_wr_data,
  output logic [rv_isa_pkg::XLEN-1:0]   o_rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]   o_rs2_data
);

  logic [rv_isa_pkg::XLEN-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en && i_wr_rd != '0) begin
      regs[i_wr_rd] <= i_wr_data;
    end
  end

  // Same-cycle write shows through to the read ports
  assign o_rs1_data = (i_rs1 == '0) ? '0 :
                      (i_wr_en && i_wr_rd == i_rs1) ? i_wr_data : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 :
                      (i_wr_en && i_wr_rd == i_rs2) ? i_wr_data : regs[i_rs2];

endmodule
